// File: hdl/id_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "id_params.svh"

module id_decoder import id_pkg::*; (
	input  word_t inst_i,
	output dec_t  dec_o
);

	logic [5:0] op;
	logic [5:0] funct;
	reg_addr_t  rs;
	reg_addr_t  rt;
	reg_addr_t  rd;
	logic [4:0] shamt;
	word_t      imm_zext;
	word_t      imm_sext;
	logic       valid;

	assign op       = inst_i[31:26];
	assign rs       = inst_i[25:21];
	assign rt       = inst_i[20:16];
	assign rd       = inst_i[15:11];
	assign shamt    = inst_i[10:6];
	assign funct    = inst_i[5:0];
	assign imm_zext = {16'h0000, inst_i[15:0]};
	assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};

	always_comb begin
		dec_o             = '0;
		dec_o.aluop       = `ALUOP_NOP;
		dec_o.alusel      = `ALUSEL_NOP;
		dec_o.br_kind     = `BR_NONE;
		dec_o.rs_addr     = rs;
		dec_o.rt_addr     = rt;
		dec_o.wd          = rd;
		dec_o.instr_index = inst_i[25:0];
		valid             = 1'b0;

		//////////////////////////////////////////////////////////////////////
		// control fields per opcode
		case (op)
		`EXE_SPECIAL_INST: begin
			dec_o.rs_read = 1'b1;
			dec_o.rt_read = 1'b1;
			dec_o.wreg    = 1'b1;
			valid         = (shamt == 5'd0);
			case (funct)
			`EXE_AND, `EXE_OR, `EXE_XOR, `EXE_NOR:
				dec_o.alusel = `ALUSEL_LOGIC;
			`EXE_SLLV, `EXE_SRLV, `EXE_SRAV:
				dec_o.alusel = `ALUSEL_SHIFT;
			`EXE_ADD, `EXE_ADDU, `EXE_SUB, `EXE_SUBU, `EXE_SLT, `EXE_SLTU:
				dec_o.alusel = `ALUSEL_ARITHMETIC;
			// shift amount rides in the immediate
			`EXE_SLL, `EXE_SRL, `EXE_SRA: begin
				dec_o.alusel  = `ALUSEL_SHIFT;
				dec_o.rs_read = 1'b0;
				dec_o.imm     = word_t'(shamt);
				valid         = (rs == 5'd0);
			end
			`EXE_JR: begin
				dec_o.alusel  = `ALUSEL_JUMP_BRANCH;
				dec_o.rt_read = 1'b0;
				dec_o.wreg    = 1'b0;
				dec_o.br_kind = `BR_JREG;
				valid         = (inst_i[20:6] == 15'd0);
			end
			`EXE_JALR: begin
				dec_o.alusel  = `ALUSEL_JUMP_BRANCH;
				dec_o.rt_read = 1'b0;
				dec_o.link    = 1'b1;
				dec_o.br_kind = `BR_JREG;
				valid         = (rt == 5'd0) && (shamt == 5'd0);
			end
			default: valid = 1'b0;
			endcase
			case (funct)
			`EXE_AND:             dec_o.aluop = `ALUOP_AND;
			`EXE_OR:              dec_o.aluop = `ALUOP_OR;
			`EXE_XOR:             dec_o.aluop = `ALUOP_XOR;
			`EXE_NOR:             dec_o.aluop = `ALUOP_NOR;
			`EXE_SLL, `EXE_SLLV:  dec_o.aluop = `ALUOP_SLL;
			`EXE_SRL, `EXE_SRLV:  dec_o.aluop = `ALUOP_SRL;
			`EXE_SRA, `EXE_SRAV:  dec_o.aluop = `ALUOP_SRA;
			`EXE_ADD:             dec_o.aluop = `ALUOP_ADD;
			`EXE_ADDU:            dec_o.aluop = `ALUOP_ADDU;
			`EXE_SUB:             dec_o.aluop = `ALUOP_SUB;
			`EXE_SUBU:            dec_o.aluop = `ALUOP_SUBU;
			`EXE_SLT:             dec_o.aluop = `ALUOP_SLT;
			`EXE_SLTU:            dec_o.aluop = `ALUOP_SLTU;
			`EXE_JR:              dec_o.aluop = `ALUOP_JR;
			`EXE_JALR:            dec_o.aluop = `ALUOP_JALR;
			default:              dec_o.aluop = `ALUOP_NOP;
			endcase
		end
		// rt[4] selects the linking form, rt[0] the sense of the test
		`EXE_REGIMM_INST: begin
			dec_o.alusel  = `ALUSEL_JUMP_BRANCH;
			dec_o.rs_read = 1'b1;
			dec_o.br_kind = rt[0] ? `BR_GEZ : `BR_LTZ;
			dec_o.link    = rt[4];
			dec_o.wreg    = rt[4];
			dec_o.wd      = reg_addr_t'(`ID_LINK_REG);
			valid         = 1'b1;
			case (rt)
			`EXE_BLTZ:   dec_o.aluop = `ALUOP_BLTZ;
			`EXE_BGEZ:   dec_o.aluop = `ALUOP_BGEZ;
			`EXE_BLTZAL: dec_o.aluop = `ALUOP_BLTZAL;
			`EXE_BGEZAL: dec_o.aluop = `ALUOP_BGEZAL;
			default:     valid = 1'b0;
			endcase
		end
		// jal is the odd opcode of the pair
		`EXE_J, `EXE_JAL: begin
			dec_o.alusel  = `ALUSEL_JUMP_BRANCH;
			dec_o.br_kind = `BR_JUMP;
			dec_o.link    = op[0];
			dec_o.wreg    = op[0];
			dec_o.wd      = reg_addr_t'(`ID_LINK_REG);
			valid         = 1'b1;
		end
		`EXE_BEQ, `EXE_BNE, `EXE_BLEZ, `EXE_BGTZ: begin
			dec_o.alusel  = `ALUSEL_JUMP_BRANCH;
			dec_o.rs_read = 1'b1;
			// blez and bgtz compare against zero only
			dec_o.rt_read = !op[1];
			valid         = !op[1] || (rt == 5'd0);
			case (op)
			`EXE_BEQ:  dec_o.br_kind = `BR_EQ;
			`EXE_BNE:  dec_o.br_kind = `BR_NE;
			`EXE_BLEZ: dec_o.br_kind = `BR_LEZ;
			default:   dec_o.br_kind = `BR_GTZ;
			endcase
		end
		`EXE_ANDI, `EXE_ORI, `EXE_XORI, `EXE_LUI: begin
			dec_o.alusel  = `ALUSEL_LOGIC;
			dec_o.rs_read = 1'b1;
			dec_o.wreg    = 1'b1;
			dec_o.wd      = rt;
			dec_o.imm     = imm_zext;
			valid         = 1'b1;
			if (op == `EXE_LUI) begin
				dec_o.imm = {inst_i[15:0], 16'h0000};
				valid     = (rs == 5'd0);
			end
		end
		`EXE_ADDI, `EXE_ADDIU, `EXE_SLTI, `EXE_SLTIU: begin
			dec_o.alusel  = `ALUSEL_ARITHMETIC;
			dec_o.rs_read = 1'b1;
			dec_o.wreg    = 1'b1;
			dec_o.wd      = rt;
			dec_o.imm     = imm_sext;
			valid         = 1'b1;
		end
		`EXE_LB, `EXE_LH, `EXE_LW, `EXE_LBU, `EXE_LHU,
		`EXE_SB, `EXE_SH, `EXE_SW: begin
			dec_o.alusel  = `ALUSEL_LOAD_STORE;
			dec_o.rs_read = 1'b1;
			// stores read rt as data, loads write it
			dec_o.rt_read = op[3];
			dec_o.wreg    = !op[3];
			dec_o.wd      = rt;
			dec_o.imm     = imm_sext;
			valid         = 1'b1;
		end
		default: valid = 1'b0;
		endcase

		// operation codes of the plain opcodes
		case (op)
		`EXE_J:            dec_o.aluop = `ALUOP_J;
		`EXE_JAL:          dec_o.aluop = `ALUOP_JAL;
		`EXE_BEQ:          dec_o.aluop = `ALUOP_BEQ;
		`EXE_BNE:          dec_o.aluop = `ALUOP_BNE;
		`EXE_BLEZ:         dec_o.aluop = `ALUOP_BLEZ;
		`EXE_BGTZ:         dec_o.aluop = `ALUOP_BGTZ;
		`EXE_ANDI:         dec_o.aluop = `ALUOP_AND;
		`EXE_ORI, `EXE_LUI: dec_o.aluop = `ALUOP_OR;
		`EXE_XORI:         dec_o.aluop = `ALUOP_XOR;
		`EXE_ADDI:         dec_o.aluop = `ALUOP_ADDI;
		`EXE_ADDIU:        dec_o.aluop = `ALUOP_ADDIU;
		`EXE_SLTI:         dec_o.aluop = `ALUOP_SLT;
		`EXE_SLTIU:        dec_o.aluop = `ALUOP_SLTU;
		`EXE_LB:           dec_o.aluop = `ALUOP_LB;
		`EXE_LH:           dec_o.aluop = `ALUOP_LH;
		`EXE_LW:           dec_o.aluop = `ALUOP_LW;
		`EXE_LBU:          dec_o.aluop = `ALUOP_LBU;
		`EXE_LHU:          dec_o.aluop = `ALUOP_LHU;
		`EXE_SB:           dec_o.aluop = `ALUOP_SB;
		`EXE_SH:           dec_o.aluop = `ALUOP_SH;
		`EXE_SW:           dec_o.aluop = `ALUOP_SW;
		default: ;
		endcase

		// an invalid word goes down the pipe as a nop
		if (!valid) begin
			dec_o.aluop   = `ALUOP_NOP;
			dec_o.alusel  = `ALUSEL_NOP;
			dec_o.wreg    = 1'b0;
			dec_o.rs_read = 1'b0;
			dec_o.rt_read = 1'b0;
			dec_o.br_kind = `BR_NONE;
			dec_o.link    = 1'b0;
			dec_o.invalid = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/id_issue.sv
`timescale 1ns/1ps
`default_nettype none
`include "id_params.svh"

module id_issue import id_pkg::*; (
	input  logic  clk,
	input  logic  rst_i,
	input  word_t pc_i,
	input  word_t inst_i,
	input  dec_t  dec_i,
	input  word_t reg1_i,
	input  word_t reg2_i,
	input  logic  stall_i,
	output logic  branch_flag_o,
	output word_t branch_target_o,
	output logic  next_in_delayslot_o,
	output exe_t  exe_o
);

	word_t pc_plus_4;
	word_t pc_plus_8;
	word_t br_offset;
	word_t target;
	logic  take;
	logic  in_delayslot_q;
	exe_t  exe_d;
	exe_t  exe_q;

	assign pc_plus_4 = pc_i + word_t'(4);
	assign pc_plus_8 = pc_i + word_t'(8);
	assign br_offset = {{14{dec_i.instr_index[15]}}, dec_i.instr_index[15:0], 2'b00};

	//////////////////////////////////////////////////////////////////////
	// branch resolution
	always_comb begin
		case (dec_i.br_kind)
		`BR_JUMP, `BR_JREG: take = 1'b1;
		`BR_EQ:             take = (reg1_i == reg2_i);
		`BR_NE:             take = (reg1_i != reg2_i);
		`BR_GTZ:            take = !reg1_i[31] && (reg1_i != '0);
		`BR_LEZ:            take = reg1_i[31] || (reg1_i == '0);
		`BR_GEZ:            take = !reg1_i[31];
		`BR_LTZ:            take = reg1_i[31];
		default:            take = 1'b0;
		endcase

		case (dec_i.br_kind)
		`BR_JUMP: target = {pc_plus_4[31:28], dec_i.instr_index, 2'b00};
		`BR_JREG: target = reg1_i;
		default:  target = pc_plus_4 + br_offset;
		endcase
	end

	// operands are stale while stalled
	assign branch_flag_o       = take && !stall_i;
	assign branch_target_o     = branch_flag_o ? target : '0;
	assign next_in_delayslot_o = (dec_i.br_kind != `BR_NONE);

	always_comb begin
		exe_d.aluop        = dec_i.aluop;
		exe_d.alusel       = dec_i.alusel;
		exe_d.reg1         = reg1_i;
		exe_d.reg2         = reg2_i;
		exe_d.wd           = dec_i.wd;
		exe_d.wreg         = dec_i.wreg;
		exe_d.link_addr    = dec_i.link ? pc_plus_8 : '0;
		exe_d.in_delayslot = in_delayslot_q;
		exe_d.inst         = inst_i;
	end

	//////////////////////////////////////////////////////////////////////
	// id/ex register
	always_ff @(posedge clk) begin
		if (rst_i || stall_i) begin
			exe_q.aluop        <= `ALUOP_NOP;
			exe_q.alusel       <= `ALUSEL_NOP;
			exe_q.wreg         <= 1'b0;
			exe_q.in_delayslot <= 1'b0;
		end else begin
			exe_q <= exe_d;
		end
	end

	// delay slot flag for the instruction after a branch
	always_ff @(posedge clk) begin
		if (rst_i) begin
			in_delayslot_q <= 1'b0;
		end else if (!stall_i) begin
			in_delayslot_q <= next_in_delayslot_o;
		end
	end

	assign exe_o = exe_q;

endmodule

`default_nettype wire

// File: hdl/id_operand.sv
`timescale 1ns/1ps
`default_nettype none

module id_operand import id_pkg::*; (
	input  logic      read_i,
	input  reg_addr_t addr_i,
	input  word_t     imm_i,
	input  word_t     rf_data_i,
	input  fwd_t      ex_fwd_i,
	input  fwd_t      mem_fwd_i,
	input  logic      ex_load_i,
	output word_t     operand_o,
	output logic      stall_o
);

	logic ex_hit;
	logic mem_hit;

	assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
	assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

	// load data is not ready until after mem
	assign stall_o = read_i && ex_load_i && (ex_fwd_i.wd == addr_i);

	always_comb begin
		if (!read_i) begin
			operand_o = imm_i;
		end else if (ex_hit) begin
			operand_o = ex_fwd_i.wdata;
		end else if (mem_hit) begin
			operand_o = mem_fwd_i.wdata;
		end else begin
			operand_o = rf_data_i;
		end
	end

endmodule

`default_nettype wire

// File: hdl/id_params.svh
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// widths
`define ID_WORD_W         32
`define ID_REG_ADDR_W     5
`define ID_INSTR_INDEX_W  26
`define ID_ALUOP_W        8
`define ID_ALUSEL_W       3
`define ID_BR_KIND_W      4
`define ID_LINK_REG       31

//////////////////////////////////////////////////////////////////////
// opcode field
`define EXE_SPECIAL_INST  6'b000000
`define EXE_REGIMM_INST   6'b000001
`define EXE_J             6'b000010
`define EXE_JAL           6'b000011
`define EXE_BEQ           6'b000100
`define EXE_BNE           6'b000101
`define EXE_BLEZ          6'b000110
`define EXE_BGTZ          6'b000111
`define EXE_ADDI          6'b001000
`define EXE_ADDIU         6'b001001
`define EXE_SLTI          6'b001010
`define EXE_SLTIU         6'b001011
`define EXE_ANDI          6'b001100
`define EXE_ORI           6'b001101
`define EXE_XORI          6'b001110
`define EXE_LUI           6'b001111
`define EXE_LB            6'b100000
`define EXE_LH            6'b100001
`define EXE_LW            6'b100011
`define EXE_LBU           6'b100100
`define EXE_LHU           6'b100101
`define EXE_SB            6'b101000
`define EXE_SH            6'b101001
`define EXE_SW            6'b101011

// funct field of special
`define EXE_SLL           6'b000000
`define EXE_SRL           6'b000010
`define EXE_SRA           6'b000011
`define EXE_SLLV          6'b000100
`define EXE_SRLV          6'b000110
`define EXE_SRAV          6'b000111
`define EXE_JR            6'b001000
`define EXE_JALR          6'b001001
`define EXE_ADD           6'b100000
`define EXE_ADDU          6'b100001
`define EXE_SUB           6'b100010
`define EXE_SUBU          6'b100011
`define EXE_AND           6'b100100
`define EXE_OR            6'b100101
`define EXE_XOR           6'b100110
`define EXE_NOR           6'b100111
`define EXE_SLT           6'b101010
`define EXE_SLTU          6'b101011

// rt field of regimm
`define EXE_BLTZ          5'b00000
`define EXE_BGEZ          5'b00001
`define EXE_BLTZAL        5'b10000
`define EXE_BGEZAL        5'b10001

//////////////////////////////////////////////////////////////////////
// result class for execute
`define ALUSEL_NOP         3'b000
`define ALUSEL_LOGIC       3'b001
`define ALUSEL_SHIFT       3'b010
`define ALUSEL_ARITHMETIC  3'b100
`define ALUSEL_JUMP_BRANCH 3'b110
`define ALUSEL_LOAD_STORE  3'b111

// operation for execute
`define ALUOP_NOP         8'b00000000
`define ALUOP_AND         8'b00100100
`define ALUOP_OR          8'b00100101
`define ALUOP_XOR         8'b00100110
`define ALUOP_NOR         8'b00100111
`define ALUOP_SLL         8'b01111100
`define ALUOP_SRL         8'b00000010
`define ALUOP_SRA         8'b00000011
`define ALUOP_SLT         8'b00101010
`define ALUOP_SLTU        8'b00101011
`define ALUOP_ADD         8'b00100000
`define ALUOP_ADDU        8'b00100001
`define ALUOP_SUB         8'b00100010
`define ALUOP_SUBU        8'b00100011
`define ALUOP_ADDI        8'b01010101
`define ALUOP_ADDIU       8'b01010110
`define ALUOP_J           8'b01001111
`define ALUOP_JAL         8'b01010000
`define ALUOP_JR          8'b00001000
`define ALUOP_JALR        8'b00001001
`define ALUOP_BEQ         8'b01010001
`define ALUOP_BNE         8'b01010010
`define ALUOP_BLEZ        8'b01010011
`define ALUOP_BGTZ        8'b01010100
`define ALUOP_BLTZ        8'b01000000
`define ALUOP_BGEZ        8'b01000001
`define ALUOP_BLTZAL      8'b01001010
`define ALUOP_BGEZAL      8'b01001011
`define ALUOP_LB          8'b11100000
`define ALUOP_LH          8'b11100001
`define ALUOP_LW          8'b11100011
`define ALUOP_LBU         8'b11100100
`define ALUOP_LHU         8'b11100101
`define ALUOP_SB          8'b11101000
`define ALUOP_SH          8'b11101001
`define ALUOP_SW          8'b11101011

// branch kinds
`define BR_NONE           4'd0
`define BR_JUMP           4'd1
`define BR_JREG           4'd2
`define BR_EQ             4'd3
`define BR_NE             4'd4
`define BR_GTZ            4'd5
`define BR_LEZ            4'd6
`define BR_GEZ            4'd7
`define BR_LTZ            4'd8

`endif

// File: hdl/id_pkg.sv
`default_nettype none
`include "id_params.svh"

package id_pkg;

	typedef logic [`ID_WORD_W-1:0]        word_t;
	typedef logic [`ID_REG_ADDR_W-1:0]    reg_addr_t;
	typedef logic [`ID_ALUOP_W-1:0]       aluop_t;
	typedef logic [`ID_ALUSEL_W-1:0]      alusel_t;
	typedef logic [`ID_BR_KIND_W-1:0]     br_kind_t;
	// low half doubles as the branch offset
	typedef logic [`ID_INSTR_INDEX_W-1:0] instr_index_t;

	typedef struct packed {
		aluop_t       aluop;
		alusel_t      alusel;
		reg_addr_t    wd;
		logic         wreg;
		logic         rs_read;
		logic         rt_read;
		reg_addr_t    rs_addr;
		reg_addr_t    rt_addr;
		word_t        imm;
		br_kind_t     br_kind;
		logic         link;
		logic         invalid;
		instr_index_t instr_index;
	} dec_t;

	// writeback seen from a later stage
	typedef struct packed {
		logic      wreg;
		reg_addr_t wd;
		word_t     wdata;
	} fwd_t;

	typedef struct packed {
		aluop_t    aluop;
		alusel_t   alusel;
		word_t     reg1;
		word_t     reg2;
		reg_addr_t wd;
		logic      wreg;
		word_t     link_addr;
		logic      in_delayslot;
		word_t     inst;
	} exe_t;

endpackage

`default_nettype wire

// File: hdl/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,
	input  word_t     pc_i,
	input  word_t     inst_i,
	input  word_t     rf_rs_data_i,
	input  word_t     rf_rt_data_i,
	input  fwd_t      ex_fwd_i,
	input  fwd_t      mem_fwd_i,
	input  logic      ex_load_i,
	output logic      rf_rs_read_o,
	output logic      rf_rt_read_o,
	output reg_addr_t rf_rs_addr_o,
	output reg_addr_t rf_rt_addr_o,
	output logic      stall_o,
	output logic      branch_flag_o,
	output word_t     branch_target_o,
	output logic      next_in_delayslot_o,
	output logic      inst_invalid_o,
	output exe_t      exe_o
);

	dec_t  dec;
	word_t rs_operand;
	word_t rt_operand;
	logic  rs_stall;
	logic  rt_stall;

	assign rf_rs_read_o   = dec.rs_read;
	assign rf_rt_read_o   = dec.rt_read;
	assign rf_rs_addr_o   = dec.rs_addr;
	assign rf_rt_addr_o   = dec.rt_addr;
	assign inst_invalid_o = dec.invalid;
	assign stall_o        = rs_stall | rt_stall;

	id_decoder u_decoder (
		.inst_i (inst_i),
		.dec_o  (dec)
	);

	//////////////////////////////////////////////////////////////////////
	// operand select, one per source
	id_operand u_op_rs (
		.read_i    (dec.rs_read),
		.addr_i    (dec.rs_addr),
		.imm_i     (dec.imm),
		.rf_data_i (rf_rs_data_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.ex_load_i (ex_load_i),
		.operand_o (rs_operand),
		.stall_o   (rs_stall)
	);

	id_operand u_op_rt (
		.read_i    (dec.rt_read),
		.addr_i    (dec.rt_addr),
		.imm_i     (dec.imm),
		.rf_data_i (rf_rt_data_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.ex_load_i (ex_load_i),
		.operand_o (rt_operand),
		.stall_o   (rt_stall)
	);

	id_issue u_issue (
		.clk                 (clk),
		.rst_i               (rst_i),
		.pc_i                (pc_i),
		.inst_i              (inst_i),
		.dec_i               (dec),
		.reg1_i              (rs_operand),
		.reg2_i              (rt_operand),
		.stall_i             (stall_o),
		.branch_flag_o       (branch_flag_o),
		.branch_target_o     (branch_target_o),
		.next_in_delayslot_o (next_in_delayslot_o),
		.exe_o               (exe_o)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -f tb.f --top-module tb_id_stage \
	&& ./obj_dir/Vtb_id_stage > "$LOG" 2>&1 \
	|| echo "build or simulation did not complete" >> "$LOG"

cat "$LOG"
grep -qx "Regression passed" "$LOG" && exit 0 || exit 1

// File: tb.f
+incdir+hdl
hdl/id_pkg.sv
hdl/id_decoder.sv
hdl/id_operand.sv
hdl/id_issue.sv
hdl/id_stage.sv
test/tb_id_stage.sv

// File: test/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "id_params.svh"

module tb_id_stage import id_pkg::*; ();

	localparam int TEST_CYCLES    = 200;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic      clk;
	logic      rst_i;
	word_t     pc_i;
	word_t     inst_i;
	word_t     rf_rs_data_i;
	word_t     rf_rt_data_i;
	fwd_t      ex_fwd_i;
	fwd_t      mem_fwd_i;
	logic      ex_load_i;
	logic      rf_rs_read_o;
	logic      rf_rt_read_o;
	reg_addr_t rf_rs_addr_o;
	reg_addr_t rf_rt_addr_o;
	logic      stall_o;
	logic      branch_flag_o;
	word_t     branch_target_o;
	logic      next_in_delayslot_o;
	logic      inst_invalid_o;
	exe_t      exe_o;

	word_t rf [0:31];
	word_t seed_word;
	int    cycle_count = 0;
	int    err_count = 0;
	int    check_count = 0;
	int    test_count = 0;
	int    test_start_errs = 0;

	// register file model
	assign rf_rs_data_i = rf[rf_rs_addr_o];
	assign rf_rt_data_i = rf[rf_rt_addr_o];

	id_stage i_dut (
		.clk                 (clk),
		.rst_i               (rst_i),
		.pc_i                (pc_i),
		.inst_i              (inst_i),
		.rf_rs_data_i        (rf_rs_data_i),
		.rf_rt_data_i        (rf_rt_data_i),
		.ex_fwd_i            (ex_fwd_i),
		.mem_fwd_i           (mem_fwd_i),
		.ex_load_i           (ex_load_i),
		.rf_rs_read_o        (rf_rs_read_o),
		.rf_rt_read_o        (rf_rt_read_o),
		.rf_rs_addr_o        (rf_rs_addr_o),
		.rf_rt_addr_o        (rf_rt_addr_o),
		.stall_o             (stall_o),
		.branch_flag_o       (branch_flag_o),
		.branch_target_o     (branch_target_o),
		.next_in_delayslot_o (next_in_delayslot_o),
		.inst_invalid_o      (inst_invalid_o),
		.exe_o               (exe_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles without finishing", cycle_count);
			$display("Regression failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// instruction encodings and expected values

	function automatic word_t r_type(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
		logic [4:0] sa, logic [5:0] fn);
		return {`EXE_SPECIAL_INST, rs, rt, rd, sa, fn};
	endfunction

	function automatic word_t i_type(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_type(logic [5:0] op, instr_index_t idx);
		return {op, idx};
	endfunction

	function automatic word_t sext16(logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic word_t zext16(logic [15:0] imm);
		return {16'h0000, imm};
	endfunction

	function automatic word_t branch_dest(word_t pc, logic [15:0] off);
		word_t offset;
		offset = sext16(off);
		return pc + 32'd4 + {offset[29:0], 2'b00};
	endfunction

	function automatic word_t jump_dest(word_t pc, instr_index_t idx);
		word_t next_pc;
		next_pc = pc + 32'd4;
		return {next_pc[31:28], idx, 2'b00};
	endfunction

	function automatic fwd_t bypass(logic wreg, reg_addr_t wd, word_t wdata);
		fwd_t f;
		f.wreg  = wreg;
		f.wd    = wd;
		f.wdata = wdata;
		return f;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// compare tasks

	task automatic check_word(string name, word_t got, word_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(string name, reg_addr_t got, reg_addr_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR t=%0t %s got %0d exp %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_aluop(string name, aluop_t got, aluop_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
		end
	endtask

	task automatic check_alusel(string name, alusel_t got, alusel_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
		end
	endtask

	task automatic check_exe(aluop_t aluop, alusel_t alusel, reg_addr_t wd, logic wreg,
		word_t reg1, word_t reg2);
		check_aluop("exe_o.aluop", exe_o.aluop, aluop);
		check_alusel("exe_o.alusel", exe_o.alusel, alusel);
		check_addr("exe_o.wd", exe_o.wd, wd);
		check_bit("exe_o.wreg", exe_o.wreg, wreg);
		check_word("exe_o.reg1", exe_o.reg1, reg1);
		check_word("exe_o.reg2", exe_o.reg2, reg2);
	endtask

	task automatic check_bubble();
		check_aluop("exe_o.aluop", exe_o.aluop, `ALUOP_NOP);
		check_alusel("exe_o.alusel", exe_o.alusel, `ALUSEL_NOP);
		check_bit("exe_o.wreg", exe_o.wreg, 1'b0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// sequencing, all called on a falling edge

	task automatic drive(word_t pc, word_t inst);
		pc_i   = pc;
		inst_i = inst;
	endtask

	task automatic tick();
		@(negedge clk);
	endtask

	task automatic open_test();
		test_start_errs = err_count;
	endtask

	task automatic close_test(string name);
		test_count++;
		if (err_count == test_start_errs) begin
			$display("test %-10s ok", name);
		end else begin
			$display("test %-10s FAILED with %0d errors", name, err_count - test_start_errs);
		end
	endtask

	task automatic test_reset();
		open_test();
		check_bubble();
		check_bit("exe_o.in_delayslot", exe_o.in_delayslot, 1'b0);
		#1;
		check_bit("stall_o", stall_o, 1'b0);
		check_bit("branch_flag_o", branch_flag_o, 1'b0);
		tick();
		close_test("reset");
	endtask

	task automatic test_alu();
		word_t pc;
		open_test();
		pc = 32'h0000_1000;
		drive(pc, r_type(5'd1, 5'd2, 5'd3, 5'd0, `EXE_ADDU));
		tick();
		check_exe(`ALUOP_ADDU, `ALUSEL_ARITHMETIC, 5'd3, 1'b1, rf[1], rf[2]);
		drive(pc + 32'd4, i_type(`EXE_ORI, 5'd4, 5'd5, 16'h8a3c));
		#1;
		check_bit("rf_rs_read_o", rf_rs_read_o, 1'b1);
		check_bit("rf_rt_read_o", rf_rt_read_o, 1'b0);
		check_addr("rf_rs_addr_o", rf_rs_addr_o, 5'd4);
		check_addr("rf_rt_addr_o", rf_rt_addr_o, 5'd5);
		tick();
		check_exe(`ALUOP_OR, `ALUSEL_LOGIC, 5'd5, 1'b1, rf[4], zext16(16'h8a3c));
		check_word("exe_o.inst", exe_o.inst, i_type(`EXE_ORI, 5'd4, 5'd5, 16'h8a3c));
		drive(pc + 32'd8, i_type(`EXE_LUI, 5'd0, 5'd6, 16'h1234));
		tick();
		check_exe(`ALUOP_OR, `ALUSEL_LOGIC, 5'd6, 1'b1, 32'h0, 32'h1234_0000);
		// negative immediate
		drive(pc + 32'd12, i_type(`EXE_ADDI, 5'd8, 5'd7, 16'hfffb));
		tick();
		check_exe(`ALUOP_ADDI, `ALUSEL_ARITHMETIC, 5'd7, 1'b1, rf[8], 32'hffff_fffb);
		drive(pc + 32'd16, r_type(5'd0, 5'd10, 5'd9, 5'd7, `EXE_SLL));
		tick();
		check_exe(`ALUOP_SLL, `ALUSEL_SHIFT, 5'd9, 1'b1, 32'd7, rf[10]);
		check_bit("exe_o.in_delayslot", exe_o.in_delayslot, 1'b0);
		close_test("alu");
	endtask

	task automatic test_forward();
		word_t ex_val;
		word_t mem_val;
		word_t inst;
		open_test();
		ex_val  = $urandom;
		mem_val = $urandom;
		inst    = r_type(5'd1, 5'd2, 5'd3, 5'd0, `EXE_ADDU);
		drive(32'h0000_2000, inst);
		ex_fwd_i  = bypass(1'b1, 5'd1, ex_val);
		mem_fwd_i = bypass(1'b1, 5'd1, mem_val);
		tick();
		check_exe(`ALUOP_ADDU, `ALUSEL_ARITHMETIC, 5'd3, 1'b1, ex_val, rf[2]);
		ex_fwd_i = bypass(1'b1, 5'd4, ex_val);
		tick();
		check_word("exe_o.reg1", exe_o.reg1, mem_val);
		// rs bypasses both miss, rt gets the memory value
		mem_fwd_i = bypass(1'b1, 5'd2, mem_val);
		tick();
		check_word("exe_o.reg1", exe_o.reg1, rf[1]);
		check_word("exe_o.reg2", exe_o.reg2, mem_val);
		ex_fwd_i  = bypass(1'b0, 5'd1, ex_val);
		mem_fwd_i = bypass(1'b0, 5'd1, mem_val);
		tick();
		check_word("exe_o.reg1", exe_o.reg1, rf[1]);
		ex_fwd_i  = '0;
		mem_fwd_i = '0;
		close_test("forward");
	endtask

	task automatic test_load_use();
		open_test();
		drive(32'h0000_3000, r_type(5'd1, 5'd2, 5'd3, 5'd0, `EXE_ADDU));
		ex_load_i = 1'b1;
		ex_fwd_i  = bypass(1'b1, 5'd2, $urandom);
		#1;
		check_bit("stall_o", stall_o, 1'b1);
		tick();
		check_bubble();
		// load done, same word still held upstream
		ex_load_i = 1'b0;
		ex_fwd_i  = '0;
		#1;
		check_bit("stall_o", stall_o, 1'b0);
		tick();
		check_exe(`ALUOP_ADDU, `ALUSEL_ARITHMETIC, 5'd3, 1'b1, rf[1], rf[2]);
		ex_load_i = 1'b1;
		ex_fwd_i  = bypass(1'b1, 5'd7, $urandom);
		#1;
		check_bit("stall_o", stall_o, 1'b0);
		tick();
		ex_load_i = 1'b0;
		ex_fwd_i  = '0;
		close_test("load_use");
	endtask

	task automatic run_branch(word_t pc, word_t inst, logic taken, word_t target,
		aluop_t aluop, logic link);
		drive(pc, inst);
		#1;
		check_bit("branch_flag_o", branch_flag_o, taken);
		if (taken) begin
			check_word("branch_target_o", branch_target_o, target);
		end
		check_bit("next_in_delayslot_o", next_in_delayslot_o, 1'b1);
		tick();
		check_aluop("exe_o.aluop", exe_o.aluop, aluop);
		check_alusel("exe_o.alusel", exe_o.alusel, `ALUSEL_JUMP_BRANCH);
		check_bit("exe_o.wreg", exe_o.wreg, link);
		check_bit("exe_o.in_delayslot", exe_o.in_delayslot, 1'b0);
		if (link) begin
			check_addr("exe_o.wd", exe_o.wd, 5'd31);
			check_word("exe_o.link_addr", exe_o.link_addr, pc + 32'd8);
		end
		// delay slot
		drive(pc + 32'd4, r_type(5'd1, 5'd2, 5'd3, 5'd0, `EXE_ADDU));
		#1;
		check_bit("next_in_delayslot_o", next_in_delayslot_o, 1'b0);
		tick();
		check_aluop("exe_o.aluop", exe_o.aluop, `ALUOP_ADDU);
		check_bit("exe_o.in_delayslot", exe_o.in_delayslot, 1'b1);
	endtask

	task automatic test_branch();
		word_t pc;
		open_test();
		rf[11] = $urandom;
		rf[12] = rf[11];
		rf[13] = ~rf[11];
		rf[14] = $urandom | 32'h8000_0000;
		rf[15] = $urandom & 32'hffff_fffc;
		pc = 32'h0040_0100;
		run_branch(pc, i_type(`EXE_BEQ, 5'd11, 5'd12, 16'h0010), 1'b1,
			branch_dest(pc, 16'h0010), `ALUOP_BEQ, 1'b0);
		pc = 32'h0040_0200;
		run_branch(pc, i_type(`EXE_BEQ, 5'd11, 5'd13, 16'h0020), 1'b0,
			32'h0, `ALUOP_BEQ, 1'b0);
		pc = 32'h0040_0300;
		run_branch(pc, i_type(`EXE_REGIMM_INST, 5'd14, `EXE_BLTZAL, 16'hfff0), 1'b1,
			branch_dest(pc, 16'hfff0), `ALUOP_BLTZAL, 1'b1);
		pc = 32'h3fff_fffc;
		run_branch(pc, j_type(`EXE_J, 26'h2b4c3d1), 1'b1,
			jump_dest(pc, 26'h2b4c3d1), `ALUOP_J, 1'b0);
		pc = 32'h0040_0400;
		run_branch(pc, r_type(5'd15, 5'd0, 5'd0, 5'd0, `EXE_JR), 1'b1,
			rf[15], `ALUOP_JR, 1'b0);
		close_test("branch");
	endtask

	task automatic test_invalid();
		open_test();
		drive(32'h0000_5000, {6'b111111, 26'h0123456});
		#1;
		check_bit("inst_invalid_o", inst_invalid_o, 1'b1);
		check_bit("branch_flag_o", branch_flag_o, 1'b0);
		tick();
		check_bit("exe_o.wreg", exe_o.wreg, 1'b0);
		check_aluop("exe_o.aluop", exe_o.aluop, `ALUOP_NOP);
		// nonzero shamt on addu
		drive(32'h0000_5004, r_type(5'd1, 5'd2, 5'd3, 5'd4, `EXE_ADDU));
		#1;
		check_bit("inst_invalid_o", inst_invalid_o, 1'b1);
		tick();
		check_bit("exe_o.wreg", exe_o.wreg, 1'b0);
		drive(32'h0000_5008, r_type(5'd1, 5'd2, 5'd3, 5'd0, `EXE_ADDU));
		#1;
		check_bit("inst_invalid_o", inst_invalid_o, 1'b0);
		tick();
		close_test("invalid");
	endtask

	initial begin
		rst_i     = 1'b1;
		pc_i      = '0;
		inst_i    = '0;
		ex_fwd_i  = '0;
		mem_fwd_i = '0;
		ex_load_i = 1'b0;
		seed_word = $urandom(32'h9a10_cee3);
		rf[0]     = '0;
		for (int i = 1; i < 32; i++) begin
			rf[i] = $urandom;
		end

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;

		test_reset();
		test_alu();
		test_forward();
		test_load_use();
		test_branch();
		test_invalid();

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
